//--- project.f
cart_pkg.sv
rom_header_parse.sv
cheat_code_loader.sv
backup_ram_sync.sv
cart_loader_top.sv
cart_loader_properties.sv
tb_cart_loader.sv

//--- run.sh
#!/bin/sh
# Compile and run with Verilator, result taken from the log
verilator --binary --timing --assert --top-module tb_cart_loader -f project.f -o sim_cart \
	|| exit 1
./obj_dir/sim_cart +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q "Finished with errors" sim.log && exit 1
grep -q "Finished with no errors" sim.log || exit 1
exit 0

//--- tb_cart_loader.sv
// ==============================
// Testbench for cart_loader_top
// Checking is done by the bound properties
// Storage model answers requests after 3 to 6 cycles
// ==============================
`timescale 1ns/1ps

module tb_cart_loader;

	localparam int NUM_TESTS       = 6;
	localparam int MAX_TEST_CYCLES = 3000;

	logic                   clk_sys = 1'b0;
	logic                   reset;
	cart_pkg::dl_beat_t     dl_beat;
	logic                   dl_wr, dl_active, dl_is_code;
	cart_pkg::header_mode_e header_mode;
	logic                   bk_load, bk_save, img_mounted, img_readonly, img_nonempty;
	logic                   sd_ack;
	cart_pkg::cart_info_t   cart_info;
	cart_pkg::cheat_code_t  cheat_code;
	logic                   cheat_valid, cheat_clear, sd_rd, sd_wr, bk_busy, bk_loading;
	logic [31:0]            sd_lba;
	logic [31:0]            lcg_state = 32'h5f88_cac5;
	int                     tb_errors = 0;
	int                     last_errors = 0;

	cart_loader_top u_dut (.*);

	always #50 clk_sys = ~clk_sys;

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic put_beat(input logic [24:0] addr, input logic [15:0] data, input logic code);
		@(negedge clk_sys);
		dl_beat.addr = addr;
		dl_beat.data = data;
		dl_active    = 1'b1;
		dl_is_code   = code;
		dl_wr        = 1'b1;
		@(negedge clk_sys);
		dl_wr = 1'b0;
	endtask

	task automatic end_download();
		repeat (2) @(negedge clk_sys);
		dl_active = 1'b0;
		repeat (2) @(negedge clk_sys);
	endtask

	task automatic wait_transfer(input string what);
		int   n;
		logic started;
		n = 0;
		while (!bk_busy && n < 20) begin
			@(negedge clk_sys);
			n++;
		end
		started = bk_busy;
		while (bk_busy && n < 1000) begin
			@(negedge clk_sys);
			n++;
		end
		if (!started) begin
			$display("%s transfer never started", what);
			tb_errors++;
		end else if (bk_busy) begin
			$display("%s transfer did not finish in time", what);
			tb_errors++;
		end
	endtask

	task automatic report_test(input string name);
		int now;
		now = tb_errors + u_dut.u_props.fail_count;
		$display("test %s done, %0d errors", name, now - last_errors);
		last_errors = now;
	endtask

	// Storage acknowledge model
	initial begin
		int delay;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if ((sd_rd || sd_wr) && !sd_ack) begin
				delay = 3 + int'(next_rand() % 4);
				repeat (delay - 1) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (4) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	initial begin
		repeat (NUM_TESTS * MAX_TEST_CYCLES) @(posedge clk_sys);
		$display("watchdog expired before the tests finished");
		$display("Finished with errors");
		$finish;
	end

	initial begin
		logic [31:0] r;
		reset = 1'b0;
		dl_beat = '0;
		{dl_wr, dl_active, dl_is_code} = 3'b000;
		header_mode = cart_pkg::hdr_auto;
		{bk_load, bk_save, img_mounted, img_readonly, img_nonempty} = 5'b00000;
		repeat (4) @(negedge clk_sys);
		reset = 1'b1;
		repeat (3) @(negedge clk_sys);
		report_test("reset");

		r = next_rand();
		put_beat(25'd0, {r[15:8], (r[7:0] == 8'd0) ? 8'h01 : r[7:0]}, 1'b0);
		put_beat(25'd2, 16'(next_rand()), 1'b0);
		end_download();
		report_test("auto header");

		// LoROM then HiROM with a beat at the other mode's address
		header_mode = cart_pkg::hdr_lorom;
		put_beat(25'd0, 16'(next_rand()), 1'b0);
		put_beat(cart_pkg::LOROM_HDR_BASE + 25'd512, 16'(next_rand()), 1'b0);
		put_beat(cart_pkg::LOROM_HDR_BASE + 25'd514, 16'(next_rand()), 1'b0);
		put_beat(cart_pkg::HIROM_HDR_BASE + 25'd512, 16'(next_rand()), 1'b0);
		end_download();
		header_mode = cart_pkg::hdr_hirom;
		put_beat(25'd0, 16'(next_rand()), 1'b0);
		put_beat(cart_pkg::HIROM_HDR_BASE + 25'd512, 16'(next_rand()), 1'b0);
		put_beat(cart_pkg::HIROM_HDR_BASE + 25'd514, 16'(next_rand()), 1'b0);
		put_beat(cart_pkg::LOROM_HDR_BASE + 25'd514, 16'(next_rand()), 1'b0);
		end_download();
		report_test("lorom hirom");

		for (int i = 0; i < 8; i++)
			put_beat(25'(2 * i), 16'(next_rand()), 1'b1);
		end_download();
		report_test("cheat");

		// RAM size code 1 gives a mask of 0x7FF and four sectors
		header_mode = cart_pkg::hdr_auto;
		{img_mounted, img_readonly, img_nonempty} = 3'b100;
		put_beat(25'd0, 16'h001C, 1'b0);
		end_download();
		bk_save = 1'b1;
		wait_transfer("save");
		bk_save = 1'b0;
		report_test("save");

		img_nonempty = 1'b1;
		put_beat(25'd0, 16'h001C, 1'b0);
		end_download();
		wait_transfer("auto-load");
		img_readonly = 1'b1;
		put_beat(25'd0, 16'h001C, 1'b0);
		end_download();
		repeat (50) @(negedge clk_sys);
		report_test("auto-load");

		$display("tests run %0d, errors %0d", NUM_TESTS, last_errors);
		if (last_errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

//--- cart_loader_properties.sv
// ==============================
// Checks for cart_loader_top, attached with bind
// Expected header, cheat and sector values are kept as shadows
// fail_count is read by the testbench
// ==============================
`timescale 1ns/1ps

module cart_loader_properties #(
	parameter int SECTOR_BYTES_LOG2 = 9
) (
	input logic                   clk_sys,
	input logic                   reset,
	input cart_pkg::dl_beat_t     dl_beat,
	input logic                   dl_wr,
	input logic                   dl_active,
	input logic                   dl_is_code,
	input cart_pkg::header_mode_e header_mode,
	input logic                   img_mounted,
	input logic                   img_readonly,
	input cart_pkg::cart_info_t   cart_info,
	input cart_pkg::cheat_code_t  cheat_code,
	input logic                   cheat_valid,
	input logic                   cheat_clear,
	input logic                   sd_rd,
	input logic                   sd_wr,
	input logic [31:0]            sd_lba,
	input logic                   bk_busy,
	input logic                   bk_loading
);

	int          fail_count = 0;
	logic [3:0]  exp_rom_sz;
	logic [3:0]  exp_ram_sz;
	logic [7:0]  exp_type;
	logic        exp_region;
	logic        hdr_en;
	logic [24:0] hdr_addr;
	logic [15:0] code_words [8];
	logic        exp_enable;
	logic        cart_q;
	logic        req_q;
	logic [7:0]  req_count;
	logic        cart_wr_s;
	logic        code_wr_s;
	logic        code_last;
	logic [23:0] exp_rom_mask;
	logic [23:0] exp_ram_mask;

	assign cart_wr_s = dl_wr && dl_active && !dl_is_code;
	assign code_wr_s = dl_wr && dl_active && dl_is_code;
	assign code_last = code_wr_s && dl_beat.addr[3:0] == 4'd14;

	// ==============================
	// Header shadow

	assign hdr_en = header_mode inside {cart_pkg::hdr_lorom, cart_pkg::hdr_hirom,
		cart_pkg::hdr_exhirom};

	always_comb begin
		case (header_mode)
			cart_pkg::hdr_lorom:   hdr_addr = 25'h000_7FD6 + 25'd512;
			cart_pkg::hdr_hirom:   hdr_addr = 25'h000_FFD6 + 25'd512;
			cart_pkg::hdr_exhirom: hdr_addr = 25'h040_FFD6 + 25'd512;
			default:               hdr_addr = '0;
		endcase
		exp_rom_mask = 24'((32'd1 << ({1'b0, exp_rom_sz} + 5'd10)) - 32'd1);
		exp_ram_mask = (exp_ram_sz == 4'd0) ? 24'd0 :
			24'((32'd1 << ({1'b0, exp_ram_sz} + 5'd10)) - 32'd1);
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			exp_rom_sz <= 4'hC;
			exp_ram_sz <= 4'd0;
			exp_type   <= 8'd0;
			exp_region <= 1'b0;
		end else if (cart_wr_s) begin
			if (dl_beat.addr == 25'd0) begin
				exp_rom_sz <= (header_mode == cart_pkg::hdr_auto &&
					dl_beat.data[7:0] != 8'd0) ? dl_beat.data[3:0] : 4'hC;
				exp_ram_sz <= (header_mode == cart_pkg::hdr_auto) ? dl_beat.data[7:4] : 4'd0;
				case (header_mode)
					cart_pkg::hdr_auto:    exp_type <= dl_beat.data[15:8];
					cart_pkg::hdr_hirom:   exp_type <= 8'd1;
					cart_pkg::hdr_exhirom: exp_type <= 8'd2;
					default:               exp_type <= 8'd0;
				endcase
			end
			if (dl_beat.addr == 25'd2)
				exp_region <= dl_beat.data[8];
			if (hdr_en && dl_beat.addr == hdr_addr)
				exp_rom_sz <= dl_beat.data[11:8];
			if (hdr_en && dl_beat.addr == hdr_addr + 25'd2)
				exp_ram_sz <= dl_beat.data[3:0];
		end
	end

	// ==============================
	// Cheat and backup shadows

	always_ff @(posedge clk_sys) begin
		if (code_wr_s && !dl_beat.addr[0])
			code_words[dl_beat.addr[3:1]] <= dl_beat.data;
	end

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			exp_enable <= 1'b0;
			cart_q     <= 1'b0;
			req_q      <= 1'b0;
			req_count  <= 8'd0;
		end else begin
			cart_q <= dl_active && !dl_is_code;
			req_q  <= sd_rd || sd_wr;
			if (dl_active && !dl_is_code && !cart_q)
				exp_enable <= 1'b0;
			else if (dl_active && !dl_is_code && img_mounted && !img_readonly)
				exp_enable <= cart_info.ram_mask != 24'd0;
			if (!bk_busy)
				req_count <= 8'd0;
			else if ((sd_rd || sd_wr) && !req_q)
				req_count <= req_count + 8'd1;
		end
	end

	// ==============================
	// Assertions

	a_reset: assert property (@(posedge clk_sys) $rose(reset) |->
		!cheat_valid && !sd_rd && !sd_wr && !bk_busy && cart_info.rom_mask == 24'h3F_FFFF)
	else begin
		fail_count++;
		$error("mismatch at %0t: reset state", $time);
	end

	a_header: assert property (@(posedge clk_sys) disable iff (!reset)
		cart_info == {exp_type, exp_rom_mask, exp_ram_mask, exp_region})
	else begin
		fail_count++;
		$error("mismatch at %0t: cart info", $time);
	end

	a_cheat_strobe: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_valid == $past(code_last))
	else begin
		fail_count++;
		$error("mismatch at %0t: cheat strobe", $time);
	end

	a_cheat_code: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_valid |-> cheat_code == {code_words[1], code_words[0], code_words[3],
			code_words[2], code_words[5], code_words[4], code_words[7], code_words[6]})
	else begin
		fail_count++;
		$error("mismatch at %0t: cheat code", $time);
	end

	// Cartridge download or a code list restart drops old codes
	a_cheat_clear: assert property (@(posedge clk_sys) disable iff (!reset)
		cheat_clear == (cart_q || $past(code_wr_s && dl_beat.addr == 25'd0)))
	else begin
		fail_count++;
		$error("mismatch at %0t: cheat clear", $time);
	end

	a_one_dir: assert property (@(posedge clk_sys) disable iff (!reset) !(sd_rd && sd_wr))
	else begin
		fail_count++;
		$error("mismatch at %0t: rd and wr", $time);
	end

	a_lba: assert property (@(posedge clk_sys) disable iff (!reset)
		$rose(sd_rd || sd_wr) |-> sd_lba == 32'(req_count) && bk_loading == sd_rd)
	else begin
		fail_count++;
		$error("mismatch at %0t: sector lba", $time);
	end

	a_enable: assert property (@(posedge clk_sys) disable iff (!reset)
		$rose(bk_busy) |-> $past(exp_enable))
	else begin
		fail_count++;
		$error("mismatch at %0t: enable", $time);
	end

	a_count: assert property (@(posedge clk_sys) disable iff (!reset)
		$fell(bk_busy) |-> req_count == 8'((cart_info.ram_mask >> SECTOR_BYTES_LOG2) + 24'd1))
	else begin
		fail_count++;
		$error("mismatch at %0t: sectors", $time);
	end

endmodule

bind cart_loader_top cart_loader_properties #(
	.SECTOR_BYTES_LOG2 (SECTOR_BYTES_LOG2)
) u_props (.*);

//--- cart_loader_top.sv
// ==============================
// Cartridge loading top level
// Download stream cannot be stalled, every dl_wr is taken
// dl_is_code selects cheat words, otherwise the beat is cartridge data
// cheat_clear is registered, one cycle behind its cause
// ==============================
`timescale 1ns/1ps

module cart_loader_top #(
	parameter int SECTOR_BYTES_LOG2 = 9
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  cart_pkg::dl_beat_t     dl_beat,
	input  logic                   dl_wr,
	input  logic                   dl_active,
	input  logic                   dl_is_code,
	input  cart_pkg::header_mode_e header_mode,
	input  logic                   bk_load,
	input  logic                   bk_save,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_nonempty,
	input  logic                   sd_ack,
	output cart_pkg::cart_info_t   cart_info,
	output cart_pkg::cheat_code_t  cheat_code,
	output logic                   cheat_valid,
	output logic                   cheat_clear,
	output logic                   sd_rd,
	output logic                   sd_wr,
	output logic [31:0]            sd_lba,
	output logic                   bk_busy,
	output logic                   bk_loading
);

	logic cart_active;
	logic cart_wr;
	logic code_wr;

	// ==============================
	// Stream split

	assign cart_active = dl_active && !dl_is_code;
	assign cart_wr     = dl_wr && cart_active;
	assign code_wr     = dl_wr && dl_active && dl_is_code;

	// Old codes are dropped on a new cartridge or a new code list
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_clear <= 1'b0;
		end else begin
			cheat_clear <= cart_active || (code_wr && dl_beat.addr == 25'd0);
		end
	end

	// ==============================
	// Blocks

	rom_header_parse u_header (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.cart_wr     (cart_wr),
		.dl_beat     (dl_beat),
		.header_mode (header_mode),
		.cart_info   (cart_info)
	);

	cheat_code_loader u_cheat (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.code_wr     (code_wr),
		.dl_beat     (dl_beat),
		.cheat_code  (cheat_code),
		.cheat_valid (cheat_valid)
	);

	backup_ram_sync #(
		.SECTOR_BYTES_LOG2 (SECTOR_BYTES_LOG2)
	) u_backup (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cart_active  (cart_active),
		.ram_mask     (cart_info.ram_mask),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonempty (img_nonempty),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.bk_busy      (bk_busy),
		.bk_loading   (bk_loading)
	);

endmodule

//--- backup_ram_sync.sv
// ==============================
// Backup RAM sector sequencer
// Storage side answers each request with an sd_ack pulse
// Request drops on the ack rise, next sector follows the ack fall
// Sector count comes from ram_mask, sampled at each ack fall
// Commands only act while idle and enabled
// ==============================
`timescale 1ns/1ps

module backup_ram_sync #(
	parameter int SECTOR_BYTES_LOG2 = 9
) (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        cart_active,
	input  logic [23:0] ram_mask,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic        img_nonempty,
	input  logic        sd_ack,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic [31:0] sd_lba,
	output logic        bk_busy,
	output logic        bk_loading
);

	cart_pkg::bk_state_e state;

	logic        old_load;
	logic        old_save;
	logic        old_cart;
	logic        old_ack;
	logic        bk_enable;
	logic        load_rise;
	logic        save_rise;
	logic        auto_load;
	logic        ack_rise;
	logic        ack_fall;
	logic        start_read;
	logic        start_write;
	logic [23:0] last_lba;
	logic        last_sector;

	// ==============================
	// Edge detection and enable

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_cart <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_cart <= cart_active;
			old_ack  <= sd_ack;
		end
	end

	assign load_rise = bk_load && !old_load;
	assign save_rise = bk_save && !old_save;
	assign ack_rise  = sd_ack && !old_ack;
	assign ack_fall  = !sd_ack && old_ack;
	// Save image is mounted by the time the download ends
	assign auto_load = old_cart && !cart_active && img_nonempty;

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			bk_enable <= 1'b0;
		end else if (cart_active && !old_cart) begin
			bk_enable <= 1'b0;
		end else if (cart_active && img_mounted && !img_readonly) begin
			bk_enable <= |ram_mask;
		end
	end

	// Auto-load wins over a save in the same cycle
	assign start_read  = bk_enable && (load_rise || auto_load);
	assign start_write = bk_enable && save_rise && !start_read;

	assign last_lba    = ram_mask >> SECTOR_BYTES_LOG2;
	assign last_sector = (sd_lba >= {8'd0, last_lba});

	// ==============================
	// Sector FSM

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			state      <= cart_pkg::bk_idle;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= 32'd0;
			bk_loading <= 1'b0;
		end else begin
			case (state)
				cart_pkg::bk_idle: begin
					if (start_read || start_write) begin
						state      <= cart_pkg::bk_request;
						sd_lba     <= 32'd0;
						sd_rd      <= start_read;
						sd_wr      <= !start_read;
						bk_loading <= start_read;
					end
				end
				cart_pkg::bk_request: begin
					// Storage has taken the request
					if (ack_rise) begin
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= cart_pkg::bk_wait_release;
					end
				end
				cart_pkg::bk_wait_release: begin
					if (ack_fall) begin
						if (last_sector) begin
							state      <= cart_pkg::bk_idle;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + 32'd1;
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
							state  <= cart_pkg::bk_request;
						end
					end
				end
				default: state <= cart_pkg::bk_idle;
			endcase
		end
	end

	assign bk_busy = (state != cart_pkg::bk_idle);

endmodule

//--- cheat_code_loader.sv
// ==============================
// Cheat code assembly from eight download words
// Word at low nibble 14 completes the code
// Odd byte addresses are ignored
// ==============================
`timescale 1ns/1ps

module cheat_code_loader (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  code_wr,
	input  cart_pkg::dl_beat_t    dl_beat,
	output cart_pkg::cheat_code_t cheat_code,
	output logic                  cheat_valid
);

	logic [127:0] code_bits;
	logic [1:0]   field_sel;
	logic         half_sel;
	logic [6:0]   word_lsb;
	logic         last_word;

	// Field order is flags, address, compare, replace from the top down
	assign field_sel = dl_beat.addr[3:2];
	assign half_sel  = dl_beat.addr[1];
	assign word_lsb  = {~field_sel, half_sel, 4'b0000};
	assign last_word = (dl_beat.addr[3:0] == 4'd14);

	always_ff @(posedge clk_sys) begin
		if (code_wr && !dl_beat.addr[0]) begin
			code_bits[word_lsb +: 16] <= dl_beat.data;
		end
	end

	// One-cycle strobe after the last word
	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			cheat_valid <= 1'b0;
		end else begin
			cheat_valid <= code_wr && last_word;
		end
	end

	assign cheat_code = cart_pkg::cheat_code_t'(code_bits);

endmodule

//--- rom_header_parse.sv
// ==============================
// Cartridge header detection from the download stream
// Only beats with cart_wr set are looked at
// Internal header is used in LoROM, HiROM and ExHiROM modes only
// Masks follow the registered size codes one cycle after the beat
// ==============================
`timescale 1ns/1ps

module rom_header_parse (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   cart_wr,
	input  cart_pkg::dl_beat_t     dl_beat,
	input  cart_pkg::header_mode_e header_mode,
	output cart_pkg::cart_info_t   cart_info
);

	localparam logic [23:0] MASK_UNIT = 24'(cart_pkg::MASK_UNIT_BYTES);

	logic [3:0]  rom_size;
	logic [3:0]  ram_size;
	logic [7:0]  rom_type;
	logic        region;
	logic        int_hdr_en;
	logic [24:0] int_hdr_base;
	logic [24:0] rom_size_addr;
	logic [24:0] ram_size_addr;

	// ==============================
	// Internal header location

	always_comb begin
		int_hdr_en = 1'b1;
		case (header_mode)
			cart_pkg::hdr_lorom:   int_hdr_base = cart_pkg::LOROM_HDR_BASE;
			cart_pkg::hdr_hirom:   int_hdr_base = cart_pkg::HIROM_HDR_BASE;
			cart_pkg::hdr_exhirom: int_hdr_base = cart_pkg::EXHIROM_HDR_BASE;
			default: begin
				int_hdr_en   = 1'b0;
				int_hdr_base = '0;
			end
		endcase
	end

	// Image carries the copier header in front
	assign rom_size_addr = int_hdr_base + 25'(cart_pkg::COPIER_HEADER_BYTES);
	assign ram_size_addr = rom_size_addr + 25'(cart_pkg::RAM_SIZE_OFFSET);

	// ==============================
	// Size, type and region

	always_ff @(posedge clk_sys) begin
		if (!reset) begin
			rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
			ram_size <= 4'd0;
			rom_type <= 8'd0;
			region   <= 1'b0;
		end else if (cart_wr) begin
			if (dl_beat.addr == 25'd0) begin
				rom_size <= cart_pkg::DEFAULT_ROM_SIZE;
				ram_size <= 4'd0;
				// Size word only trusted in auto mode
				if (header_mode == cart_pkg::hdr_auto && dl_beat.data[7:0] != 8'd0) begin
					{ram_size, rom_size} <= dl_beat.data[7:0];
				end
				case (header_mode)
					cart_pkg::hdr_none:    rom_type <= 8'd0;
					cart_pkg::hdr_lorom:   rom_type <= 8'd0;
					cart_pkg::hdr_hirom:   rom_type <= 8'd1;
					cart_pkg::hdr_exhirom: rom_type <= 8'd2;
					default:               rom_type <= dl_beat.data[15:8];
				endcase
			end
			if (dl_beat.addr == 25'd2) begin
				region <= dl_beat.data[8];
			end
			if (int_hdr_en && dl_beat.addr == rom_size_addr) begin
				rom_size <= dl_beat.data[11:8];
			end
			if (int_hdr_en && dl_beat.addr == ram_size_addr) begin
				ram_size <= dl_beat.data[3:0];
			end
		end
	end

	// ==============================
	// Published info

	always_comb begin
		cart_info.rom_type = rom_type;
		cart_info.rom_mask = (MASK_UNIT << rom_size) - 24'd1;
		// No backup RAM for size code 0
		cart_info.ram_mask = (ram_size == 4'd0) ? 24'd0 : (MASK_UNIT << ram_size) - 24'd1;
		cart_info.region   = region;
	end

endmodule

//--- cart_pkg.sv
// ==============================
// Shared types and constants for the cartridge loader
// Download addresses are byte offsets, one 16-bit word per beat
// Header bases exclude the copier header, add COPIER_HEADER_BYTES
// Size codes give masks of MASK_UNIT_BYTES shifted left by the code
// ==============================
package cart_pkg;

	// ==============================
	// Download stream

	// One download write
	typedef struct packed {
		logic [24:0] addr;
		logic [15:0] data;
	} dl_beat_t;

	// Header mode setting from the menu
	typedef enum logic [2:0] {
		hdr_auto    = 3'd0,
		hdr_none    = 3'd1,
		hdr_lorom   = 3'd2,
		hdr_hirom   = 3'd3,
		hdr_exhirom = 3'd4
	} header_mode_e;

	// ==============================
	// Detected cartridge and cheat codes

	// Region 1 means PAL
	typedef struct packed {
		logic [7:0]  rom_type;
		logic [23:0] rom_mask;
		logic [23:0] ram_mask;
		logic        region;
	} cart_info_t;

	// Fields arrive as low then high word each
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] address;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	// Backup RAM sector sequencer
	typedef enum logic [1:0] {
		bk_idle,
		bk_request,
		bk_wait_release
	} bk_state_e;

	// ==============================
	// Header constants

	localparam int          COPIER_HEADER_BYTES = 512;
	localparam logic [3:0]  DEFAULT_ROM_SIZE    = 4'hC;
	localparam int          MASK_UNIT_BYTES     = 1024;
	localparam logic [24:0] LOROM_HDR_BASE      = 25'h000_7FD6;
	localparam logic [24:0] HIROM_HDR_BASE      = 25'h000_FFD6;
	localparam logic [24:0] EXHIROM_HDR_BASE    = 25'h040_FFD6;
	// RAM size byte sits after the ROM size byte
	localparam int          RAM_SIZE_OFFSET     = 2;

endpackage
